//--- fb_pkg.sv
// framebuffer package
// geometry, 720p timing defaults, pixel and address types, drawer states

`default_nettype none

package fb_pkg;

    // framebuffer geometry
    localparam int fb_width  = 160;
    localparam int fb_height = 120;
    localparam int fb_pixels = fb_width * fb_height;

    typedef logic        [14:0] fb_addr_t;  // pixel address into the framebuffer
    typedef logic        [3:0]  pix_t;      // grey pixel
    typedef logic signed [15:0] coord_t;    // screen coordinate, negative in blanking
    typedef logic        [7:0]  colour_t;   // one output colour channel

    localparam pix_t box_colr = 4'hF;  // border colour

    // 1280x720 at 60 Hz
    localparam int h_active_def = 1280;
    localparam int h_fp_def     = 110;
    localparam int h_sync_def   = 40;
    localparam int h_bp_def     = 220;
    localparam int v_active_def = 720;
    localparam int v_fp_def     = 5;
    localparam int v_sync_def   = 5;
    localparam int v_bp_def     = 20;

    // border walk, in drawing order
    typedef enum logic [2:0] {
        IDLE,
        TOP,
        RIGHT,
        LEFT,
        BOTTOM,
        DONE
    } draw_state_t;

endpackage

`default_nettype wire

//--- disp_if.sv
// display raster interface
// screen coordinates, syncs, data enable and frame strobe

`timescale 1ns/10ps
`default_nettype none

interface disp_if;
    import fb_pkg::*;

    coord_t sx;     // horizontal position, 0 at first active pixel
    coord_t sy;     // vertical position
    logic   hsync;  // positive polarity
    logic   vsync;
    logic   de;     // active picture area
    logic   frame;  // one cycle at the start of the total raster

    modport src (
        output sx, sy, hsync, vsync, de, frame
    );

    modport snk (
        input sx, sy, hsync, vsync, de, frame
    );

endinterface

`default_nettype wire

//--- display_timing.sv
// display timing generator
// counts pixels and lines, decodes syncs, data enable and the frame strobe

`timescale 1ns/10ps
`default_nettype none

module display_timing #(
    parameter int h_active = fb_pkg::h_active_def,
    parameter int h_fp     = fb_pkg::h_fp_def,
    parameter int h_sync   = fb_pkg::h_sync_def,
    parameter int h_bp     = fb_pkg::h_bp_def,
    parameter int v_active = fb_pkg::v_active_def,
    parameter int v_fp     = fb_pkg::v_fp_def,
    parameter int v_sync   = fb_pkg::v_sync_def,
    parameter int v_bp     = fb_pkg::v_bp_def
) (
    input wire logic clk_pix,
    input wire logic rst_n,
    disp_if.src      disp
);
    import fb_pkg::*;

    // blanking comes first, so the counters start negative
    localparam int h_sta  = -(h_fp + h_sync + h_bp);
    localparam int hs_sta = h_sta + h_fp;
    localparam int hs_end = hs_sta + h_sync;
    localparam int ha_end = h_active - 1;
    localparam int v_sta  = -(v_fp + v_sync + v_bp);
    localparam int vs_sta = v_sta + v_fp;
    localparam int vs_end = vs_sta + v_sync;
    localparam int va_end = v_active - 1;

    coord_t sx_nxt;
    coord_t sy_nxt;

    always_comb begin
        sx_nxt = disp.sx + 16'sd1;
        sy_nxt = disp.sy;
        if (disp.sx == ha_end) begin  // end of line
            sx_nxt = coord_t'(h_sta);
            sy_nxt = (disp.sy == va_end) ? coord_t'(v_sta) : disp.sy + 16'sd1;
        end
    end

    // decode from the next position so every output lines up with sx/sy
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            disp.sx    <= coord_t'(h_sta);
            disp.sy    <= coord_t'(v_sta);
            disp.hsync <= 1'b0;
            disp.vsync <= 1'b0;
            disp.de    <= 1'b0;
            disp.frame <= 1'b0;
        end else begin
            disp.sx    <= sx_nxt;
            disp.sy    <= sy_nxt;
            disp.hsync <= (sx_nxt >= hs_sta) && (sx_nxt < hs_end);
            disp.vsync <= (sy_nxt >= vs_sta) && (sy_nxt < vs_end);
            disp.de    <= (sx_nxt >= 0) && (sy_nxt >= 0);
            disp.frame <= (sx_nxt == h_sta) && (sy_nxt == v_sta);  // wrap to top-left
        end
    end

endmodule

`default_nettype wire

//--- fb_ram.sv
// framebuffer memory
// one write port, two registered read ports, inferred as block RAM

`timescale 1ns/10ps
`default_nettype none

module fb_ram (
    input  wire logic             clk_pix,
    input  wire logic             we,
    input  wire fb_pkg::fb_addr_t waddr,
    input  wire fb_pkg::pix_t     wdata,
    input  wire fb_pkg::fb_addr_t raddr_a,
    output fb_pkg::pix_t          rdata_a,
    input  wire fb_pkg::fb_addr_t raddr_b,
    output fb_pkg::pix_t          rdata_b
);
    import fb_pkg::*;

    pix_t mem [fb_pixels];

    // screen starts black
    initial begin
        for (int i = 0; i < fb_pixels; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clk_pix) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // port a serves the host
    always_ff @(posedge clk_pix) begin
        rdata_a <= mem[raddr_a];
    end

    // port b serves the video scan
    always_ff @(posedge clk_pix) begin
        rdata_b <= mem[raddr_b];
    end

endmodule

`default_nettype wire

//--- fb_wb_port.sv
// Wishbone classic slave for host access to the framebuffer
// shares the write port with the box drawer, drawer writes take priority

`timescale 1ns/10ps
`default_nettype none

module fb_wb_port (
    input  wire logic             clk_pix,
    input  wire logic             rst_n,
    input  wire logic             wb_cyc,
    input  wire logic             wb_stb,
    input  wire logic             wb_we,
    input  wire fb_pkg::fb_addr_t wb_adr,
    input  wire fb_pkg::pix_t     wb_dat_w,
    output fb_pkg::pix_t          wb_dat_r,
    output logic                  wb_ack,
    input  wire logic             draw_we,
    input  wire fb_pkg::fb_addr_t draw_addr,
    input  wire fb_pkg::pix_t     draw_colr,
    output logic                  we,
    output fb_pkg::fb_addr_t      waddr,
    output fb_pkg::pix_t          wdata,
    output fb_pkg::fb_addr_t      raddr,
    input  wire fb_pkg::pix_t     rdata
);
    import fb_pkg::*;

    typedef enum logic [1:0] {
        st_idle,     // waiting for a request
        st_wr_wait,  // write accepted, drawer holds the port
        st_rd_wait,  // memory read in flight
        st_ack
    } wb_state_t;

    wb_state_t state;
    logic      req;
    logic      in_range;
    logic      host_wr;
    logic      rd_valid;  // read address was inside the framebuffer

    assign req      = wb_cyc && wb_stb;
    assign in_range = wb_adr < fb_pixels;

    // host write happens in the first free slot of the request
    assign host_wr = req && wb_we && !draw_we && (state == st_idle || state == st_wr_wait);

    always_comb begin
        we    = draw_we || (host_wr && in_range);  // out-of-range writes are dropped
        waddr = draw_we ? draw_addr : wb_adr;
        wdata = draw_we ? draw_colr : wb_dat_w;
        raddr = in_range ? wb_adr : '0;
    end

    assign wb_ack = (state == st_ack);

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:
                    if (req) begin
                        if (!wb_we) state <= st_rd_wait;
                        else if (draw_we) state <= st_wr_wait;
                        else state <= st_ack;
                    end
                st_wr_wait:
                    if (!req) state <= st_idle;  // host gave up
                    else if (!draw_we) state <= st_ack;
                st_rd_wait: state <= st_ack;
                default: state <= st_idle;  // ack lasts one cycle
            endcase
        end
    end

    // read data lands the cycle before ack
    always_ff @(posedge clk_pix) begin
        if (state == st_idle) rd_valid <= in_range;
        if (state == st_rd_wait) wb_dat_r <= rd_valid ? rdata : '0;
    end

endmodule

`default_nettype wire

//--- box_drawer.sv
// box drawer
// traces a border around the framebuffer once, starting on the first frame

`timescale 1ns/10ps
`default_nettype none

module box_drawer (
    input  wire logic        clk_pix,
    input  wire logic        rst_n,
    disp_if.snk              disp,
    output logic             draw_we,
    output fb_pkg::fb_addr_t draw_addr,
    output fb_pkg::pix_t     draw_colr
);
    import fb_pkg::*;

    draw_state_t                 state;
    logic [$clog2(fb_width)-1:0] cnt;  // pixels done on the current edge

    assign draw_colr = box_colr;

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            state   <= IDLE;
            draw_we <= 1'b0;
        end else begin
            case (state)
                IDLE:
                    if (disp.frame) begin
                        draw_we   <= 1'b1;
                        draw_addr <= '0;
                        cnt       <= '0;
                        state     <= TOP;
                    end
                TOP:
                    if (cnt < fb_width - 1) begin
                        draw_addr <= draw_addr + 1'b1;
                        cnt       <= cnt + 1'b1;
                    end else begin
                        cnt   <= '0;
                        state <= RIGHT;  // start from the top-right corner
                    end
                RIGHT:
                    if (cnt < fb_height - 1) begin
                        draw_addr <= draw_addr + fb_addr_t'(fb_width);  // next row
                        cnt       <= cnt + 1'b1;
                    end else begin
                        draw_addr <= '0;
                        cnt       <= '0;
                        state     <= LEFT;
                    end
                LEFT:
                    if (cnt < fb_height - 1) begin
                        draw_addr <= draw_addr + fb_addr_t'(fb_width);
                        cnt       <= cnt + 1'b1;
                    end else begin
                        cnt   <= '0;
                        state <= BOTTOM;  // already at bottom-left
                    end
                BOTTOM:
                    if (cnt < fb_width - 1) begin
                        draw_addr <= draw_addr + 1'b1;
                        cnt       <= cnt + 1'b1;
                    end else begin
                        draw_we <= 1'b0;
                        state   <= DONE;
                    end
                default: state <= DONE;  // stays here until reset
            endcase
        end
    end

endmodule

`default_nettype wire

//--- pixel_pipeline.sv
// pixel pipeline
// scans the framebuffer with the raster and drives registered RGB and syncs

`timescale 1ns/10ps
`default_nettype none

module pixel_pipeline (
    input  wire logic         clk_pix,
    input  wire logic         rst_n,
    disp_if.snk               disp,
    output fb_pkg::fb_addr_t  raddr,
    input  wire fb_pkg::pix_t rdata,
    output logic              vid_hsync,
    output logic              vid_vsync,
    output logic              vid_de,
    output fb_pkg::colour_t   vid_r,
    output fb_pkg::colour_t   vid_g,
    output fb_pkg::colour_t   vid_b
);
    import fb_pkg::*;

    logic    paint;  // raster is inside the framebuffer area
    logic    paint_p1;
    logic    hsync_p1;
    logic    vsync_p1;
    logic    de_p1;
    colour_t grey;

    assign paint = (disp.sx >= 0) && (disp.sx < fb_width) &&
                   (disp.sy >= 0) && (disp.sy < fb_height);

    always_ff @(posedge clk_pix) begin
        if (!rst_n) raddr <= '0;
        else if (disp.frame) raddr <= '0;  // back to the top-left pixel
        else if (paint) raddr <= raddr + 1'b1;
    end

    // match the one cycle memory read
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            paint_p1 <= 1'b0;
            hsync_p1 <= 1'b0;
            vsync_p1 <= 1'b0;
            de_p1    <= 1'b0;
        end else begin
            paint_p1 <= paint;
            hsync_p1 <= disp.hsync;
            vsync_p1 <= disp.vsync;
            de_p1    <= disp.de;
        end
    end

    assign grey = paint_p1 ? {rdata, rdata} : 8'h00;  // 4 bits stretched to full range

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            vid_hsync <= 1'b0;
            vid_vsync <= 1'b0;
            vid_de    <= 1'b0;
            vid_r     <= '0;
            vid_g     <= '0;
            vid_b     <= '0;
        end else begin
            vid_hsync <= hsync_p1;
            vid_vsync <= vsync_p1;
            vid_de    <= de_p1;
            vid_r     <= grey;
            vid_g     <= grey;
            vid_b     <= grey;
        end
    end

endmodule

`default_nettype wire

//--- framebuffer_top.sv
// framebuffer video subsystem top level
// timing, framebuffer, border drawer, video pipeline and Wishbone host port

`timescale 1ns/10ps
`default_nettype none

module framebuffer_top #(
    parameter int h_active = fb_pkg::h_active_def,
    parameter int h_fp     = fb_pkg::h_fp_def,
    parameter int h_sync   = fb_pkg::h_sync_def,
    parameter int h_bp     = fb_pkg::h_bp_def,
    parameter int v_active = fb_pkg::v_active_def,
    parameter int v_fp     = fb_pkg::v_fp_def,
    parameter int v_sync   = fb_pkg::v_sync_def,
    parameter int v_bp     = fb_pkg::v_bp_def
) (
    input  wire logic             clk_pix,
    input  wire logic             rst_n,
    input  wire logic             wb_cyc,
    input  wire logic             wb_stb,
    input  wire logic             wb_we,
    input  wire fb_pkg::fb_addr_t wb_adr,
    input  wire fb_pkg::pix_t     wb_dat_w,
    output fb_pkg::pix_t          wb_dat_r,
    output logic                  wb_ack,
    output logic                  vid_hsync,
    output logic                  vid_vsync,
    output logic                  vid_de,
    output fb_pkg::colour_t       vid_r,
    output fb_pkg::colour_t       vid_g,
    output fb_pkg::colour_t       vid_b
);
    import fb_pkg::*;

    disp_if disp ();

    logic     fb_we;
    fb_addr_t fb_waddr, fb_raddr_a, fb_raddr_b;
    pix_t     fb_wdata, fb_rdata_a, fb_rdata_b;
    logic     draw_we;
    fb_addr_t draw_addr;
    pix_t     draw_colr;

    display_timing #(
        .h_active(h_active), .h_fp(h_fp), .h_sync(h_sync), .h_bp(h_bp),
        .v_active(v_active), .v_fp(v_fp), .v_sync(v_sync), .v_bp(v_bp)
    ) display_timing_inst (
        .clk_pix, .rst_n, .disp(disp.src)
    );

    fb_ram fb_ram_inst (
        .clk_pix, .we(fb_we), .waddr(fb_waddr), .wdata(fb_wdata),
        .raddr_a(fb_raddr_a), .rdata_a(fb_rdata_a),
        .raddr_b(fb_raddr_b), .rdata_b(fb_rdata_b)
    );

    fb_wb_port fb_wb_port_inst (
        .clk_pix, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .draw_we, .draw_addr, .draw_colr,
        .we(fb_we), .waddr(fb_waddr), .wdata(fb_wdata),
        .raddr(fb_raddr_a), .rdata(fb_rdata_a)  // host uses read port a
    );

    box_drawer box_drawer_inst (
        .clk_pix, .rst_n, .disp(disp.snk), .draw_we, .draw_addr, .draw_colr
    );

    pixel_pipeline pixel_pipeline_inst (
        .clk_pix, .rst_n, .disp(disp.snk),
        .raddr(fb_raddr_b), .rdata(fb_rdata_b),
        .vid_hsync, .vid_vsync, .vid_de, .vid_r, .vid_g, .vid_b
    );

endmodule

`default_nettype wire

//--- framebuffer_props.sv
// Wishbone handshake and video sync assertions
// bound into the framebuffer top level

`timescale 1ns/10ps
`default_nettype none

module framebuffer_props (
    input wire logic clk_pix,
    input wire logic rst_n,
    input wire logic wb_cyc,
    input wire logic wb_stb,
    input wire logic wb_ack,
    input wire logic vid_hsync,
    input wire logic vid_de
);

    int unsigned fail_cnt = 0;  // failed assertions so far

    ack_inside_cycle: assert property (
        @(posedge clk_pix) disable iff (!rst_n) wb_ack |-> (wb_cyc && wb_stb)
    ) else begin
        $error("wb_ack high outside a bus cycle");
        fail_cnt++;
    end

    ack_one_cycle: assert property (
        @(posedge clk_pix) disable iff (!rst_n) wb_ack |=> !wb_ack
    ) else begin
        $error("wb_ack held for more than one cycle");
        fail_cnt++;
    end

    // sync pulses sit in blanking
    hsync_outside_de: assert property (
        @(posedge clk_pix) disable iff (!rst_n) !(vid_hsync && vid_de)
    ) else begin
        $error("vid_hsync high during active video");
        fail_cnt++;
    end

endmodule

bind framebuffer_top framebuffer_props props_inst (
    .clk_pix, .rst_n, .wb_cyc, .wb_stb, .wb_ack, .vid_hsync, .vid_de
);

`default_nettype wire

//--- framebuffer_tb.sv
// framebuffer subsystem testbench
// reduced raster, Wishbone table with read-back, video compared against a pixel model

`timescale 1ns/10ps
`default_nettype none

module framebuffer_tb;
    import fb_pkg::*;

    localparam int h_act        = 200;
    localparam int v_act        = 130;
    localparam int frame_cycles = (h_act + 4 + 8 + 8) * (v_act + 2 + 2 + 2);
    localparam int rst_cycles   = 10;
    localparam int n_rand       = 6;               // random write and read-back pairs
    localparam fb_addr_t draw_time_adr = 15'd500;  // row 3, column 20

    typedef struct {
        logic     wr;
        fb_addr_t adr;
        pix_t     dat;
        pix_t     exp;  // expected read data
    } wb_op_t;

    logic     clk_pix;
    logic     rst_n;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    fb_addr_t wb_adr;
    pix_t     wb_dat_w;
    pix_t     wb_dat_r;
    logic     wb_ack;
    logic     vid_hsync;
    logic     vid_vsync;
    logic     vid_de;
    colour_t  vid_r;
    colour_t  vid_g;
    colour_t  vid_b;

    wb_op_t      ops[$];
    pix_t        ref_mem [fb_pixels];  // what the framebuffer should hold
    int unsigned lcg_state   = 14794;
    int          n_checks    = 0;
    int          n_errors    = 0;
    logic        video_check = 1'b1;
    int          frame_cnt   = 0;
    int          line_cnt    = 0;
    int          de_cnt      = 0;
    logic        de_q;
    logic        vsync_q;

    framebuffer_top #(
        .h_active(h_act), .h_fp(4), .h_sync(8), .h_bp(8),
        .v_active(v_act), .v_fp(2), .v_sync(2), .v_bp(2)
    ) framebuffer_top_inst (.*);

    initial begin
        clk_pix = 1'b0;
        forever #20 clk_pix = ~clk_pix;
    end

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;  // low bits of an LCG repeat quickly
    endfunction

    function automatic colour_t expected_colour(int row, int col);
        pix_t p;
        if (row >= fb_height || col >= fb_width) return 8'h00;  // outside the framebuffer
        p = ref_mem[row * fb_width + col];
        return {p, p};
    endfunction

    task automatic check_pix(string name, pix_t got, pix_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_colour(string name, colour_t got, colour_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        n_checks++;
        if (got != exp) begin
            n_errors++;
            $display("MISMATCH %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_reset_outputs();
        check_bit("vid_de", vid_de, 1'b0);
        check_bit("vid_hsync", vid_hsync, 1'b0);
        check_bit("vid_vsync", vid_vsync, 1'b0);
        check_bit("wb_ack", wb_ack, 1'b0);
        check_colour("vid_r", vid_r, 8'h00);
        check_colour("vid_g", vid_g, 8'h00);
        check_colour("vid_b", vid_b, 8'h00);
    endtask

    // rows 0 and 119, columns 0 and 159
    task automatic model_border();
        for (int r = 0; r < fb_height; r++) begin
            for (int c = 0; c < fb_width; c++) begin
                if (r == 0 || r == fb_height - 1 || c == 0 || c == fb_width - 1) begin
                    ref_mem[r * fb_width + c] = box_colr;
                end
            end
        end
    endtask

    task automatic build_table();
        int   row;
        int   col;
        pix_t dat;
        // corners, then one point on each edge
        ops.push_back('{1'b0, 15'd0, 4'h0, box_colr});
        ops.push_back('{1'b0, 15'd159, 4'h0, box_colr});
        ops.push_back('{1'b0, 15'd19040, 4'h0, box_colr});
        ops.push_back('{1'b0, 15'd19199, 4'h0, box_colr});
        ops.push_back('{1'b0, 15'd80, 4'h0, box_colr});
        ops.push_back('{1'b0, 15'd9600, 4'h0, box_colr});
        ops.push_back('{1'b0, 15'd9759, 4'h0, box_colr});
        ops.push_back('{1'b0, 15'd19120, 4'h0, box_colr});
        ops.push_back('{1'b0, 15'd161, 4'h0, 4'h0});  // interior stays black
        ops.push_back('{1'b0, 15'd9680, 4'h0, 4'h0});
        ops.push_back('{1'b0, 15'd19200, 4'h0, 4'h0});  // first address past the end
        ops.push_back('{1'b1, 15'd19200, 4'h9, 4'h0});
        ops.push_back('{1'b0, 15'd19200, 4'h0, 4'h0});
        ops.push_back('{1'b0, 15'h7fff, 4'h0, 4'h0});
        for (int i = 0; i < n_rand; i++) begin
            row = 1 + int'(lcg_next() % (fb_height - 2));
            col = 1 + int'(lcg_next() % (fb_width - 2));
            dat = pix_t'(lcg_next());
            ops.push_back('{1'b1, fb_addr_t'(row * fb_width + col), dat, 4'h0});
            ops.push_back('{1'b0, fb_addr_t'(row * fb_width + col), 4'h0, dat});
        end
    endtask

    task automatic wb_access(input logic wr, input fb_addr_t adr, input pix_t dat,
                             output pix_t rdat);
        int waited;
        waited = 0;
        @(posedge clk_pix);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= wr;
        wb_adr   <= adr;
        wb_dat_w <= dat;
        do begin
            @(posedge clk_pix);
            waited++;
        end while (wb_ack !== 1'b1 && waited < 2000);  // drawer may hold the port ~560 cycles
        if (wb_ack !== 1'b1) begin
            n_errors++;
            $display("Wishbone access to %h got no ack within %0d cycles", adr, waited);
        end else if (wr && adr < fb_pixels) begin
            ref_mem[adr] = dat;
        end
        rdat = wb_dat_r;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic run_watchdog(int cycles);
        repeat (cycles) @(posedge clk_pix);
        $display("run did not finish within %0d cycles", cycles);
        $display("Test FAILED");
        $finish;
    endtask

    // rebuilds raster position from the video outputs alone
    always @(posedge clk_pix) begin
        if (!rst_n) begin
            frame_cnt = 0;
            line_cnt  = 0;
            de_cnt    = 0;
            de_q      = 1'b0;
            vsync_q   = 1'b0;
        end else begin
            if (vid_vsync && !vsync_q) begin
                if (frame_cnt > 0) check_count("active lines per frame", line_cnt, v_act);
                frame_cnt++;
                line_cnt = 0;
            end
            if (vid_de) begin
                if (video_check) begin
                    check_colour("vid_r", vid_r, expected_colour(line_cnt, de_cnt));
                    check_colour("vid_g", vid_g, expected_colour(line_cnt, de_cnt));
                    check_colour("vid_b", vid_b, expected_colour(line_cnt, de_cnt));
                end
                de_cnt++;
            end else if (de_q) begin  // end of an active line
                check_count("data enable cycles per line", de_cnt, h_act);
                line_cnt++;
                de_cnt = 0;
            end
            de_q    = vid_de;
            vsync_q = vid_vsync;
        end
    end

    initial begin
        pix_t rdat;
        int   total;
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        for (int i = 0; i < fb_pixels; i++) begin
            ref_mem[i] = '0;
        end
        build_table();
        fork
            run_watchdog(4 * frame_cycles + ops.size() * 10 + rst_cycles);
        join_none

        repeat (rst_cycles) @(posedge clk_pix);
        check_reset_outputs();
        rst_n <= 1'b1;
        @(posedge clk_pix);
        check_reset_outputs();

        // drawer starts on the first strobe, this write has to wait for it
        @(posedge framebuffer_top_inst.disp.frame);
        model_border();
        wb_access(1'b1, draw_time_adr, 4'h6, rdat);
        wb_access(1'b0, draw_time_adr, 4'h0, rdat);
        check_pix("wb_dat_r", rdat, 4'h6);

        wait (frame_cnt == 3);
        video_check = 1'b0;  // table writes land while frame 3 is scanned
        foreach (ops[i]) begin
            wb_access(ops[i].wr, ops[i].adr, ops[i].dat, rdat);
            if (!ops[i].wr) check_pix("wb_dat_r", rdat, ops[i].exp);
        end
        wait (frame_cnt == 4);
        video_check = 1'b1;
        wait (line_cnt == v_act);
        @(posedge clk_pix);

        total = n_errors + framebuffer_top_inst.props_inst.fail_cnt;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 n_checks, n_errors, framebuffer_top_inst.props_inst.fail_cnt);
        if (total == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- framebuffer.f
fb_pkg.sv
disp_if.sv
display_timing.sv
fb_ram.sv
fb_wb_port.sv
box_drawer.sv
pixel_pipeline.sv
framebuffer_top.sv
framebuffer_props.sv
framebuffer_tb.sv

//--- Bender.yml
package:
  name: framebuffer

sources:
  - fb_pkg.sv
  - disp_if.sv
  - display_timing.sv
  - fb_ram.sv
  - fb_wb_port.sv
  - box_drawer.sv
  - pixel_pipeline.sv
  - framebuffer_top.sv
  - target: test
    files:
      - framebuffer_props.sv
      - framebuffer_tb.sv
